// ==== sources.f ====
+incdir+include
hdl/pic_control_pkg.sv
hdl/pic_word_pkg.sv
hdl/command_sequencer.sv
hdl/init_config_regs.sv
hdl/operation_regs.sv
hdl/ack_sequencer.sv
hdl/vector_output.sv
hdl/pic_control_top.sv
test/pic_control_tb.sv

// ==== include/pic_tb_model.svh ====
/*
  Reference model for the bytes on the data bus, and the value check.
  Included inside the testbench module. Requests are expected one-hot,
  except for the poll word, which takes the lowest set bit.
*/
`ifndef PIC_TB_MODEL_SVH
`define PIC_TB_MODEL_SVH

// Acknowledge pulses are phases 1 to 3
localparam int PHASE_IDLE = 0;
localparam int PHASE_POLL = 4;

function automatic bus_byte_t expected_byte(
    input logic       upm,
    input logic       adi,
    input bus_byte_t  icw1_byte,
    input bus_byte_t  icw2_byte,
    input int         phase,
    input logic [2:0] level,
    input irq_vec_t   request
);
    bus_byte_t  value;
    logic [2:0] poll_level;
    logic       found;
    value      = 8'h00;
    poll_level = 3'd0;
    found      = 1'b0;
    if (phase == PHASE_POLL) begin
        for (int i = 0; i < 8; i++) begin
            if (request[i] && !found) begin
                poll_level = 3'(i);
                found      = 1'b1;
            end
        end
        if (found)
            value = {5'b10000, poll_level};
    end else if (upm) begin
        // 8086 mode carries the vector on the second pulse only
        if (phase == 2)
            value = {icw2_byte[7:3], level};
    end else begin
        case (phase)
            1: value = 8'hCD;
            2: value = adi ? {icw1_byte[7:5], level, 2'b00}
                           : {icw1_byte[7:6], level, 3'b000};
            3: value = icw2_byte;
            default: value = 8'h00;
        endcase
    end
    return value;
endfunction

task automatic check(input string what, input logic [31:0] actual,
                     input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s is %0h, expected %0h",
                 $time, what, actual, expected);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first mismatch");
    end
endtask

`endif

// ==== test/pic_control_tb.sv ====
/*
  Testbench for the 8259-style control block. It plays the request
  resolver and the in-service register. Random values use $urandom
  with a fixed seed. INTA pulses are two clock cycles long.
*/
`default_nettype none

module pic_control_tb import pic_control_pkg::*; ();

    localparam int MAX_CYCLES = 3000;

    localparam host_write_t STB_ICW1   = 5'b10000;
    localparam host_write_t STB_ICW2_4 = 5'b01000;
    localparam host_write_t STB_OCW1   = 5'b00100;
    localparam host_write_t STB_OCW2   = 5'b00010;
    localparam host_write_t STB_OCW3   = 5'b00001;

    logic        clock;
    logic        reset;
    host_write_t host_write;
    bus_byte_t   data_bus;
    logic        read;
    logic        interrupt_acknowledge_n;
    irq_vec_t    interrupt, highest_level_in_service;
    bus_out_t    bus_out;
    irq_vec_t    interrupt_mask, end_of_interrupt, clear_interrupt_request;
    logic        interrupt_to_cpu, latch_in_service, freeze;
    logic        level_or_edge_triggered_config, special_fully_nest_config;
    logic        enable_read_register, read_register_isr_or_irr;

    // Programmed configuration and current bus phase, as the model sees them
    bus_byte_t   icw1_byte, icw2_byte;
    logic        cfg_upm, cfg_adi, cfg_aeoi;
    int          phase;
    irq_level_t  ack_level;
    logic        expect_drive;
    int          clear_count, eoi_count, latch_count;
    irq_vec_t    clear_seen, eoi_seen;
    int          cycle_count = 0;

    `include "pic_tb_model.svh"

    pic_control_top UUT (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Bus byte and pulse outputs sampled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            check("bus_out.drive", bus_out.drive, expect_drive);
            if (bus_out.drive)
                check("bus_out.data", bus_out.data,
                      expected_byte(cfg_upm, cfg_adi, icw1_byte, icw2_byte,
                                    phase, ack_level, interrupt));
            if (clear_interrupt_request != '0) begin
                clear_count = clear_count + 1;
                clear_seen  = clear_interrupt_request;
            end
            if (latch_in_service)
                latch_count = latch_count + 1;
            if (end_of_interrupt != '0) begin
                eoi_count = eoi_count + 1;
                eoi_seen  = end_of_interrupt;
            end
        end
    end

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clock);
        #5;
    endtask

    task automatic write_word(input host_write_t strobe, input bus_byte_t value);
        host_write = strobe;
        data_bus   = value;
        step_cycles(1);
        host_write = '0;
    endtask

    // ICW3 gets the inverted ICW4 byte, so a skipped ICW3 shows in the config
    task automatic initialize(input bus_byte_t icw1, input bus_byte_t icw2,
                              input bus_byte_t icw4);
        irq_vec_t mask_before;
        mask_before = interrupt_mask;
        icw1_byte   = icw1;
        icw2_byte   = icw2;
        cfg_adi     = icw1[2];
        cfg_upm     = icw1[0] && icw4[0];
        cfg_aeoi    = icw1[0] && icw4[1];
        write_word(STB_ICW1, icw1);
        write_word(STB_ICW2_4, icw2);
        if (!icw1[1] || icw1[0]) begin
            write_word(STB_OCW1, ~mask_before);
            check("interrupt_mask during init", interrupt_mask, mask_before);
        end
        if (!icw1[1])
            write_word(STB_ICW2_4, ~icw4);
        if (icw1[0])
            write_word(STB_ICW2_4, icw4);
        check("special_fully_nest_config", special_fully_nest_config, icw1[0] && icw4[4]);
        check("level_or_edge_triggered_config", level_or_edge_triggered_config, icw1[3]);
    endtask

    task automatic run_acknowledge(input irq_level_t level);
        irq_vec_t request;
        int       pulses;
        request     = irq_vec_t'(1) << level;
        pulses      = cfg_upm ? 2 : 3;
        clear_count = 0;
        latch_count = 0;
        eoi_count   = 0;
        ack_level   = level;
        interrupt   = request;
        step_cycles(1);
        check("interrupt_to_cpu after request", interrupt_to_cpu, 1'b1);
        for (int pulse = 1; pulse <= pulses; pulse++) begin
            phase                   = pulse;
            expect_drive            = !cfg_upm || (pulse == 2);
            interrupt_acknowledge_n = 1'b0;
            step_cycles(2);
            interrupt_acknowledge_n = 1'b1;
            expect_drive            = 1'b0;
            phase                   = PHASE_IDLE;
            // Resolver drops the request once it is in service
            interrupt               = '0;
            step_cycles(1);
        end
        check("interrupt_to_cpu after acknowledge", interrupt_to_cpu, 1'b0);
        check("clear_interrupt_request pulse count", clear_count, 1);
        check("clear_interrupt_request", clear_seen, request);
        check("latch_in_service pulse count", latch_count, 1);
        check("end_of_interrupt pulse count", eoi_count, cfg_aeoi ? 1 : 0);
        if (cfg_aeoi)
            check("automatic end_of_interrupt", eoi_seen, request);
    endtask

    task automatic run_poll(input irq_vec_t request);
        interrupt = request;
        write_word(STB_OCW3, 8'h0C);
        phase        = PHASE_POLL;
        expect_drive = 1'b1;
        read         = 1'b1;
        step_cycles(1);
        read         = 1'b0;
        expect_drive = 1'b0;
        phase        = PHASE_IDLE;
        interrupt    = '0;
        step_cycles(1);
    endtask

    initial begin : stimulus
        bus_byte_t  rand_byte;
        irq_level_t level;
        rand_byte = bus_byte_t'($urandom(32));
        reset = 1'b1;
        host_write = '0;
        data_bus = '0;
        read = 1'b0;
        interrupt_acknowledge_n = 1'b1;
        interrupt = '0;
        highest_level_in_service = '0;
        {icw1_byte, icw2_byte, cfg_upm, cfg_adi, cfg_aeoi} = '0;
        phase = PHASE_IDLE;
        ack_level = '0;
        expect_drive = 1'b0;
        {clear_count, eoi_count, clear_seen, eoi_seen} = '0;
        latch_count = 0;
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;
        check("interrupt_mask after reset", interrupt_mask, 8'hFF);
        check("interrupt_to_cpu after reset", interrupt_to_cpu, 1'b0);
        check("enable_read_register after reset", enable_read_register, 1'b1);
        check("freeze after reset", freeze, 1'b1);

        // 8086 mode, SNGL 0 with ICW4
        rand_byte = bus_byte_t'($urandom);
        initialize({rand_byte[7:5], 5'b11001}, bus_byte_t'($urandom), 8'h11);
        rand_byte = bus_byte_t'($urandom);
        write_word(STB_OCW1, rand_byte);
        check("interrupt_mask", interrupt_mask, rand_byte);
        write_word(STB_OCW3, 8'h0B);
        check("enable_read_register", enable_read_register, 1'b1);
        check("read_register_isr_or_irr", read_register_isr_or_irr, 1'b1);
        write_word(STB_OCW3, 8'h08);
        check("enable_read_register", enable_read_register, 1'b0);
        check("read_register_isr_or_irr", read_register_isr_or_irr, 1'b0);
        repeat (4) run_acknowledge(irq_level_t'($urandom % 8));

        // MCS-80 mode with ADI 0, no ICW4
        rand_byte = bus_byte_t'($urandom);
        initialize({rand_byte[7:5], 5'b10010}, bus_byte_t'($urandom), 8'h00);
        repeat (4) run_acknowledge(irq_level_t'($urandom % 8));

        // MCS-80 mode with ADI 1 and automatic EOI
        rand_byte = bus_byte_t'($urandom);
        initialize({rand_byte[7:5], 5'b10111}, bus_byte_t'($urandom), 8'h02);
        repeat (4) run_acknowledge(irq_level_t'($urandom % 8));

        eoi_count = 0;
        highest_level_in_service = irq_vec_t'(1) << ($urandom % 8);
        write_word(STB_OCW2, 8'h20);
        check("non-specific end_of_interrupt", eoi_seen, highest_level_in_service);
        level = irq_level_t'($urandom % 8);
        write_word(STB_OCW2, {5'b01100, level});
        check("specific end_of_interrupt", eoi_seen, irq_vec_t'(1) << level);
        check("end_of_interrupt pulse count", eoi_count, 2);

        run_poll('0);
        run_poll(irq_vec_t'(1) << ($urandom % 8));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/pic_control_top.sv ====
/*
  Control block of a single, non-cascaded 8259-style controller.
  Request detection, priority and the in-service register sit outside.
*/
`default_nettype none

module pic_control_top import pic_control_pkg::*, pic_word_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  host_write_t  host_write,
    input  bus_byte_t    data_bus,
    input  logic         read,
    input  logic         interrupt_acknowledge_n,
    input  irq_vec_t     interrupt,
    input  irq_vec_t     highest_level_in_service,
    output bus_out_t     bus_out,
    output logic         interrupt_to_cpu,
    output irq_vec_t     interrupt_mask,
    output irq_vec_t     end_of_interrupt,
    output irq_vec_t     clear_interrupt_request,
    output logic         latch_in_service,
    output logic         freeze,
    output logic         level_or_edge_triggered_config,
    output logic         special_fully_nest_config,
    output logic         enable_read_register,
    output logic         read_register_isr_or_irr
);

    word_write_t    word_write;
    pic_config_t    pic_config;
    control_state_t control_state;
    irq_level_t     acknowledged_level;
    logic           poll_request;
    logic           end_of_acknowledge;

    assign level_or_edge_triggered_config = pic_config.ltim;
    assign special_fully_nest_config      = pic_config.sfnm;

    command_sequencer u_command_sequencer (
        .clock      (clock),
        .reset      (reset),
        .host_write (host_write),
        .sngl       (pic_config.sngl),
        .ic4        (pic_config.ic4),
        .word_write (word_write)
    );

    init_config_regs u_init_config_regs (
        .clock      (clock),
        .reset      (reset),
        .word_write (word_write),
        .data_bus   (data_bus),
        .pic_config (pic_config)
    );

    operation_regs u_operation_regs (
        .clock                    (clock),
        .reset                    (reset),
        .word_write               (word_write),
        .data_bus                 (data_bus),
        .highest_level_in_service (highest_level_in_service),
        .aeoi                     (pic_config.aeoi),
        .end_of_acknowledge       (end_of_acknowledge),
        .acknowledged_level       (acknowledged_level),
        .interrupt_mask           (interrupt_mask),
        .end_of_interrupt         (end_of_interrupt),
        .enable_read_register     (enable_read_register),
        .read_register_isr_or_irr (read_register_isr_or_irr),
        .poll_request             (poll_request)
    );

    ack_sequencer u_ack_sequencer (
        .clock                   (clock),
        .reset                   (reset),
        .interrupt               (interrupt),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .read                    (read),
        .ocw2_write              (word_write.ocw2),
        .poll_request            (poll_request),
        .upm                     (pic_config.upm),
        .control_state           (control_state),
        .acknowledged_level      (acknowledged_level),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .freeze                  (freeze),
        .latch_in_service        (latch_in_service),
        .clear_interrupt_request (clear_interrupt_request),
        .end_of_acknowledge      (end_of_acknowledge)
    );

    vector_output u_vector_output (
        .control_state           (control_state),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .read                    (read),
        .interrupt               (interrupt),
        .acknowledged_level      (acknowledged_level),
        .pic_config              (pic_config),
        .bus_out                 (bus_out)
    );

endmodule

`default_nettype wire

// ==== hdl/vector_output.sv ====
/*
  Data bus driver for acknowledge bytes and the poll word.
  Purely combinational; the byte follows INTA and read directly.
*/
`default_nettype none

module vector_output import pic_control_pkg::*, pic_word_pkg::*; (
    input  control_state_t control_state,
    input  logic           interrupt_acknowledge_n,
    input  logic           read,
    input  irq_vec_t       interrupt,
    input  irq_level_t     acknowledged_level,
    input  pic_config_t    pic_config,
    output bus_out_t       bus_out
);

    vector_addr_t addr;

    assign addr = pic_config.vector_addr;

    always_comb begin
        bus_out = '0;
        if (!interrupt_acknowledge_n) begin
            case (control_state)
                // First pulse is seen while still in WAIT_ACK
                WAIT_ACK, ACK1: begin
                    if (!pic_config.upm)
                        bus_out = '{drive: 1'b1, data: CALL_OPCODE};
                end
                ACK2: begin
                    bus_out.drive = 1'b1;
                    if (pic_config.upm)
                        bus_out.data = {addr[10:6], acknowledged_level};
                    else if (pic_config.adi)
                        bus_out.data = {addr[2:0], acknowledged_level, 2'b00};
                    else
                        bus_out.data = {addr[2:1], acknowledged_level, 3'b000};
                end
                ACK3: bus_out = '{drive: 1'b1, data: addr[10:3]};
                default: bus_out = '0;
            endcase
        end else if ((control_state == POLL) && read) begin
            bus_out.drive = 1'b1;
            if (interrupt != '0)
                bus_out.data = {5'b10000, vec_to_level(interrupt)};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ack_sequencer.sv ====
/*
  Interrupt acknowledge and poll state machine.
  INTA is sampled on clock, so each low pulse must span at least one edge.
  8086 mode uses two pulses, MCS-80 mode three.
*/
`default_nettype none

module ack_sequencer import pic_control_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  irq_vec_t         interrupt,
    input  logic             interrupt_acknowledge_n,
    input  logic             read,
    input  logic             ocw2_write,
    input  logic             poll_request,
    input  logic             upm,
    output control_state_t   control_state,
    output irq_level_t       acknowledged_level,
    output logic             interrupt_to_cpu,
    output logic             freeze,
    output logic             latch_in_service,
    output irq_vec_t         clear_interrupt_request,
    output logic             end_of_acknowledge
);

    control_state_t next_state;
    logic           prev_ack_n;
    logic           ack_fall;
    logic           ack_rise;

    always_ff @(posedge clock) begin
        if (reset)
            prev_ack_n <= 1'b1;
        else
            prev_ack_n <= interrupt_acknowledge_n;
    end

    assign ack_fall = prev_ack_n && !interrupt_acknowledge_n;
    assign ack_rise = !prev_ack_n && interrupt_acknowledge_n;

    always_comb begin
        next_state = control_state;
        case (control_state)
            CTL_READY: begin
                if (poll_request)
                    next_state = POLL;
                else if ((interrupt != '0) && !ocw2_write)
                    next_state = WAIT_ACK;
            end
            WAIT_ACK: begin
                if (poll_request)
                    next_state = POLL;
                else if (ack_fall)
                    next_state = ACK1;
            end
            ACK1: if (ack_rise) next_state = ACK2;
            ACK2: if (ack_rise) next_state = upm ? CTL_READY : ACK3;
            ACK3: if (ack_rise) next_state = CTL_READY;
            POLL: if (read) next_state = CTL_READY;
            default: next_state = CTL_READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            control_state <= CTL_READY;
        else
            control_state <= next_state;
    end

    assign latch_in_service        = (control_state == WAIT_ACK) && (next_state != WAIT_ACK);
    assign clear_interrupt_request = latch_in_service ? interrupt : '0;
    assign end_of_acknowledge      = (control_state != CTL_READY) && (control_state != POLL)
                                     && (next_state == CTL_READY);

    always_ff @(posedge clock) begin
        if (reset) begin
            interrupt_to_cpu <= 1'b0;
            freeze           <= 1'b1;
        end else begin
            interrupt_to_cpu <= (next_state != CTL_READY) && (next_state != POLL);
            freeze           <= (next_state != CTL_READY) && (next_state != WAIT_ACK);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || end_of_acknowledge)
            acknowledged_level <= '0;
        else if (latch_in_service)
            acknowledged_level <= vec_to_level(interrupt);
    end

    // Request resolver must hold the winner until it is latched
    a_latch_needs_request: assert property (@(posedge clock) disable iff (reset)
        latch_in_service |-> (interrupt != '0));

endmodule

`default_nettype wire

// ==== hdl/operation_regs.sv ====
/*
  Mask register (OCW1), end-of-interrupt decode (OCW2 and AEOI)
  and OCW3 read-register and poll bits.
  Only non-specific and specific EOI codes act; rotation codes are ignored.
*/
`default_nettype none

module operation_regs import pic_control_pkg::*, pic_word_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  word_write_t    word_write,
    input  bus_byte_t      data_bus,
    input  irq_vec_t       highest_level_in_service,
    input  logic           aeoi,
    input  logic           end_of_acknowledge,
    input  irq_level_t     acknowledged_level,
    output irq_vec_t       interrupt_mask,
    output irq_vec_t       end_of_interrupt,
    output logic           enable_read_register,
    output logic           read_register_isr_or_irr,
    output logic           poll_request
);

    logic [1:0] eoi_code;
    irq_level_t eoi_level;

    assign eoi_code  = data_bus[OCW2_EOI_HI:OCW2_EOI_LO];
    assign eoi_level = data_bus[OCW2_LEVEL_HI:OCW2_LEVEL_LO];

    always_ff @(posedge clock) begin
        if (reset)
            interrupt_mask <= '1;
        else if (word_write.ocw1)
            interrupt_mask <= data_bus;
    end

    always_comb begin
        end_of_interrupt = '0;
        if (aeoi && end_of_acknowledge) begin
            end_of_interrupt = level_to_vec(acknowledged_level);
        end else if (word_write.ocw2) begin
            case (eoi_code)
                EOI_NONSPECIFIC: end_of_interrupt = highest_level_in_service;
                EOI_SPECIFIC:    end_of_interrupt = level_to_vec(eoi_level);
                default:         end_of_interrupt = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            enable_read_register     <= 1'b1;
            read_register_isr_or_irr <= 1'b0;
        end else if (word_write.ocw3) begin
            enable_read_register     <= data_bus[OCW3_RR];
            read_register_isr_or_irr <= data_bus[OCW3_RIS];
        end
    end

    // Sequencer enters POLL at the next edge
    assign poll_request = word_write.ocw3 && data_bus[OCW3_POLL];

endmodule

`default_nettype wire

// ==== hdl/init_config_regs.sv ====
/*
  Configuration registers loaded from ICW1, ICW2 and ICW4.
  ICW1 clears the ICW4 fields, so a sequence without ICW4
  leaves SFNM, AEOI and uPM at zero (MCS-80 mode).
*/
`default_nettype none

module init_config_regs import pic_control_pkg::*, pic_word_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  word_write_t    word_write,
    input  bus_byte_t      data_bus,
    output pic_config_t    pic_config
);

    always_ff @(posedge clock) begin
        if (reset) begin
            pic_config <= '0;
        end else begin
            if (word_write.icw1) begin
                pic_config.vector_addr[2:0] <= data_bus[7:ICW1_VADDR_LO];
                pic_config.ltim             <= data_bus[ICW1_LTIM];
                pic_config.adi              <= data_bus[ICW1_ADI];
                pic_config.sngl             <= data_bus[ICW1_SNGL];
                pic_config.ic4              <= data_bus[ICW1_IC4];
                pic_config.sfnm             <= 1'b0;
                pic_config.aeoi             <= 1'b0;
                pic_config.upm              <= 1'b0;
            end
            // A15..A8, or T7..T3 in 8086 mode
            if (word_write.icw2)
                pic_config.vector_addr[10:3] <= data_bus;
            if (word_write.icw4) begin
                pic_config.sfnm <= data_bus[ICW4_SFNM];
                pic_config.aeoi <= data_bus[ICW4_AEOI];
                pic_config.upm  <= data_bus[ICW4_UPM];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/command_sequencer.sv ====
/*
  Steps through ICW2..ICW4 after ICW1 and gates host strobes by state.
  ICW1 restarts the sequence from any state. ICW3 bytes are consumed
  but not stored, since cascading is not supported.
*/
`default_nettype none

module command_sequencer import pic_control_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  host_write_t    host_write,
    input  logic           sngl,
    input  logic           ic4,
    output word_write_t    word_write
);

    command_state_t state;
    command_state_t next_state;

    always_comb begin
        next_state = state;
        if (host_write.icw1) begin
            next_state = WRITE_ICW2;
        end else if (host_write.icw2_4) begin
            case (state)
                WRITE_ICW2: begin
                    if (!sngl)
                        next_state = WRITE_ICW3;
                    else if (ic4)
                        next_state = WRITE_ICW4;
                    else
                        next_state = CMD_READY;
                end
                WRITE_ICW3: next_state = ic4 ? WRITE_ICW4 : CMD_READY;
                default:    next_state = CMD_READY;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= CMD_READY;
        else
            state <= next_state;
    end

    always_comb begin
        word_write.icw1 = host_write.icw1;
        word_write.icw2 = host_write.icw2_4 && (state == WRITE_ICW2);
        word_write.icw4 = host_write.icw2_4 && (state == WRITE_ICW4);
        word_write.ocw1 = host_write.ocw1 && (state == CMD_READY);
        word_write.ocw2 = host_write.ocw2 && (state == CMD_READY);
        word_write.ocw3 = host_write.ocw3 && (state == CMD_READY);
    end

    // Host must not send ICW2..ICW4 bytes outside an init sequence
    a_no_icw_in_ready: assert property (@(posedge clock) disable iff (reset)
        (state == CMD_READY) |-> !host_write.icw2_4);

endmodule

`default_nettype wire

// ==== hdl/pic_word_pkg.sv ====
/*
  Command word layout of the 8259 and the decoded configuration.
  Field positions are fixed by the device.
*/
`default_nettype none

package pic_word_pkg;

    // {A15..A8 or T7..T3, A7..A5}
    typedef logic [10:0] vector_addr_t;

    typedef struct packed {
        vector_addr_t vector_addr;
        logic         ltim;
        logic         adi;
        logic         sngl;
        logic         ic4;
        logic         sfnm;
        logic         aeoi;
        logic         upm;
    } pic_config_t;

    // ICW1
    localparam int ICW1_VADDR_LO = 5;
    localparam int ICW1_LTIM     = 3;
    localparam int ICW1_ADI      = 2;
    localparam int ICW1_SNGL     = 1;
    localparam int ICW1_IC4      = 0;

    // ICW4
    localparam int ICW4_SFNM = 4;
    localparam int ICW4_AEOI = 1;
    localparam int ICW4_UPM  = 0;

    // OCW2
    localparam int OCW2_EOI_HI   = 6;
    localparam int OCW2_EOI_LO   = 5;
    localparam int OCW2_LEVEL_HI = 2;
    localparam int OCW2_LEVEL_LO = 0;

    localparam logic [1:0] EOI_NONSPECIFIC = 2'b01;
    localparam logic [1:0] EOI_SPECIFIC    = 2'b11;

    // OCW3
    localparam int OCW3_POLL = 2;
    localparam int OCW3_RR   = 1;
    localparam int OCW3_RIS  = 0;

    // MCS-80 CALL instruction
    localparam logic [7:0] CALL_OPCODE = 8'hCD;

endpackage

`default_nettype wire

// ==== hdl/pic_control_pkg.sv ====
/*
  Shared types for the 8259-style interrupt control block.
  Eight interrupt levels; one-hot vectors are indexed by level number.
*/
`default_nettype none

package pic_control_pkg;

    typedef logic [7:0] irq_vec_t;
    typedef logic [2:0] irq_level_t;
    typedef logic [7:0] bus_byte_t;

    // Raw host write strobes, one cycle each
    typedef struct packed {
        logic icw1;
        logic icw2_4;
        logic ocw1;
        logic ocw2;
        logic ocw3;
    } host_write_t;

    // Strobes after gating by the command sequencer
    typedef struct packed {
        logic icw1;
        logic icw2;
        logic icw4;
        logic ocw1;
        logic ocw2;
        logic ocw3;
    } word_write_t;

    typedef struct packed {
        logic      drive;
        bus_byte_t data;
    } bus_out_t;

    typedef enum logic [1:0] {CMD_READY, WRITE_ICW2, WRITE_ICW3, WRITE_ICW4} command_state_t;
    typedef enum logic [2:0] {CTL_READY, WAIT_ACK, ACK1, ACK2, ACK3, POLL} control_state_t;

    function automatic irq_vec_t level_to_vec(input irq_level_t level);
        irq_vec_t vec;
        vec = '0;
        vec[level] = 1'b1;
        return vec;
    endfunction

    // Lowest set bit wins; zero when nothing is set
    function automatic irq_level_t vec_to_level(input irq_vec_t vec);
        irq_level_t level;
        level = '0;
        for (int i = 7; i >= 0; i--) begin
            if (vec[i])
                level = irq_level_t'(i);
        end
        return level;
    endfunction

endpackage

`default_nettype wire
